/* rtl/poker_pkg.sv */
package poker_pkg;

    // ====================
    // Sizes
    // ====================
    localparam int NUM_RANKS   = 13;
    localparam int NUM_SUITS   = 4;
    localparam int HOLE_CARDS  = 2;
    localparam int BOARD_CARDS = 5;
    localparam int RUN_LEN     = 5;

    // Legal card numbers, 2 up to ace
    localparam logic [3:0] CARD_MIN = 4'd2;
    localparam logic [3:0] CARD_MAX = 4'd14;

    // ====================
    // Category codes
    // ====================
    localparam logic [4:0] CAT_ROYAL          = 5'd31;
    localparam logic [4:0] CAT_STRAIGHT_FLUSH = 5'd30;
    localparam logic [4:0] CAT_FOUR           = 5'd29;
    localparam logic [4:0] CAT_FULL_HOUSE     = 5'd28;
    localparam logic [4:0] CAT_FLUSH          = 5'd27;
    localparam logic [4:0] CAT_STRAIGHT       = 5'd26;
    localparam logic [4:0] CAT_THREE          = 5'd25;
    localparam logic [4:0] CAT_TWO_PAIR       = 5'd24;
    localparam logic [4:0] CAT_HIGH           = 5'd0;
    localparam logic [4:0] PAIR_BASE          = 5'd10;  // Pair code is base plus pair rank

    typedef struct packed {
        logic [3:0] num;
        logic [1:0] suit;
    } card_t;

    typedef logic [NUM_RANKS-1:0] rank_mask_t;           // Bit 0 is the deuce
    typedef rank_mask_t [NUM_SUITS-1:0] suit_masks_t;

    typedef struct packed {
        rank_mask_t present;
        rank_mask_t quads;
        rank_mask_t trips;
        rank_mask_t pairs;
        logic [1:0] trip_cnt;
        logic [2:0] pair_cnt;
        logic [1:0] flush_suit;
        logic [2:0] flush_cnt;
    } rank_stats_t;

    typedef struct packed {
        logic       found;
        rank_mask_t low_onehot;                          // All zero for the wheel
    } run_t;

    typedef enum logic [3:0] {
        ROYAL, STRAIGHT_FLUSH, FOUR, FULL_HOUSE, FLUSH,
        STRAIGHT, THREE, TWO_PAIR, PAIR, HIGH
    } hand_class_e;

    typedef struct packed {
        logic [4:0] category;
        rank_mask_t tiebreak;
    } score_t;

endpackage

/* rtl/card_decoder.sv */
`timescale 1ns/1ns

module card_decoder (
    input  logic                                       clk,
    input  logic                                       rst_n,
    input  logic                                       in_valid,
    input  poker_pkg::card_t [poker_pkg::HOLE_CARDS-1:0]  hole_cards,
    input  poker_pkg::card_t [poker_pkg::BOARD_CARDS-1:0] board_cards,
    output poker_pkg::suit_masks_t                     suit_masks,
    output logic                                       s1_valid
);
    import poker_pkg::*;

    suit_masks_t masks_d;

    // Set one rank bit in the card's suit, bad numbers are dropped
    function automatic suit_masks_t add_card(input suit_masks_t m, input card_t c);
        suit_masks_t res;
        res = m;
        if (c.num >= CARD_MIN && c.num <= CARD_MAX) begin
            res[c.suit][c.num - CARD_MIN] = 1'b1;
        end
        return res;
    endfunction

    always_comb begin
        masks_d = '0;
        for (int i = 0; i < HOLE_CARDS; i++) begin
            masks_d = add_card(masks_d, hole_cards[i]);
        end
        for (int i = 0; i < BOARD_CARDS; i++) begin
            masks_d = add_card(masks_d, board_cards[i]);
        end
    end

    // ====================
    // Stage 1 registers
    // ====================
    always_ff @(posedge clk) begin
        if (in_valid) begin
            suit_masks <= masks_d;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            s1_valid <= 1'b0;
        end else begin
            s1_valid <= in_valid;
        end
    end

endmodule

/* rtl/rank_counter.sv */
`timescale 1ns/1ns

module rank_counter (
    input  poker_pkg::suit_masks_t suit_masks,
    output poker_pkg::rank_stats_t stats
);
    import poker_pkg::*;

    logic [2:0] rank_cnt [NUM_RANKS];   // Suits holding each rank
    logic [3:0] suit_cnt [NUM_SUITS];   // Cards in each suit
    logic [1:0] flush_suit;

    always_comb begin
        for (int r = 0; r < NUM_RANKS; r++) begin
            rank_cnt[r] = '0;
            for (int s = 0; s < NUM_SUITS; s++) begin
                rank_cnt[r] = rank_cnt[r] + 3'(suit_masks[s][r]);
            end
        end
    end

    always_comb begin
        for (int s = 0; s < NUM_SUITS; s++) begin
            suit_cnt[s] = '0;
            for (int r = 0; r < NUM_RANKS; r++) begin
                suit_cnt[s] = suit_cnt[s] + 4'(suit_masks[s][r]);
            end
        end
    end

    // Lowest suit with five or more, else suit 0
    always_comb begin
        flush_suit = 2'd0;
        for (int s = NUM_SUITS - 1; s >= 0; s--) begin
            if (suit_cnt[s] >= 4'd5) begin
                flush_suit = 2'(s);
            end
        end
    end

    // ====================
    // Exact count masks
    // ====================
    always_comb begin
        stats = '0;
        for (int r = 0; r < NUM_RANKS; r++) begin
            stats.present[r] = |rank_cnt[r];
            stats.quads[r]   = (rank_cnt[r] == 3'd4);
            stats.trips[r]   = (rank_cnt[r] == 3'd3);
            stats.pairs[r]   = (rank_cnt[r] == 3'd2);
        end
        stats.trip_cnt   = 2'($countones(stats.trips));   // At most two in seven cards
        stats.pair_cnt   = 3'($countones(stats.pairs));
        stats.flush_suit = flush_suit;
        stats.flush_cnt  = suit_cnt[flush_suit][2:0];
    end

endmodule

/* rtl/run_finder.sv */
`timescale 1ns/1ns

module run_finder (
    input  poker_pkg::rank_mask_t mask,
    output poker_pkg::run_t       run
);
    import poker_pkg::*;

    logic wheel;

    // A-2-3-4-5, ace sits at the top bit
    assign wheel = &{mask[3:0], mask[NUM_RANKS-1]};

    // ====================
    // Window search
    // ====================
    always_comb begin
        run = '0;
        // Highest window first, first hit wins
        for (int lo = NUM_RANKS - RUN_LEN; lo >= 0; lo--) begin
            if (!run.found && (&mask[lo +: RUN_LEN])) begin
                run.found      = 1'b1;
                run.low_onehot = rank_mask_t'(1) << lo;
            end
        end
        if (!run.found && wheel) begin
            run.found = 1'b1;      // low_onehot stays zero
        end
    end

endmodule

/* rtl/hand_classifier.sv */
`timescale 1ns/1ns

module hand_classifier (
    input  poker_pkg::rank_stats_t                   stats,
    input  poker_pkg::run_t                          straight_run,
    input  poker_pkg::run_t [poker_pkg::NUM_SUITS-1:0] suit_runs,
    output poker_pkg::hand_class_e                   hand_class,
    output poker_pkg::run_t                          sf_run
);
    import poker_pkg::*;

    logic is_royal;
    logic is_full_house;

    // Best suited run over all suits, wheel ranks lowest
    always_comb begin
        sf_run = '0;
        for (int s = 0; s < NUM_SUITS; s++) begin
            if (suit_runs[s].found &&
                (!sf_run.found || suit_runs[s].low_onehot > sf_run.low_onehot)) begin
                sf_run = suit_runs[s];
            end
        end
    end

    // Ten to ace suited is the top window
    assign is_royal = sf_run.found && sf_run.low_onehot[NUM_RANKS-RUN_LEN];

    assign is_full_house = (stats.trip_cnt == 2'd2) ||
                           ((stats.trip_cnt != 2'd0) && (stats.pair_cnt != 3'd0));

    // ====================
    // Category priority
    // ====================
    always_comb begin
        if (is_royal)                       hand_class = ROYAL;
        else if (sf_run.found)              hand_class = STRAIGHT_FLUSH;
        else if (|stats.quads)              hand_class = FOUR;
        else if (is_full_house)             hand_class = FULL_HOUSE;
        else if (stats.flush_cnt >= 3'd5)   hand_class = FLUSH;
        else if (straight_run.found)        hand_class = STRAIGHT;
        else if (stats.trip_cnt != 2'd0)    hand_class = THREE;
        else if (stats.pair_cnt >= 3'd2)    hand_class = TWO_PAIR;
        else if (stats.pair_cnt != 3'd0)    hand_class = PAIR;
        else                                hand_class = HIGH;
    end

endmodule

/* rtl/score_encoder.sv */
`timescale 1ns/1ns

module score_encoder (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   s1_valid,
    input  poker_pkg::hand_class_e hand_class,
    input  poker_pkg::rank_stats_t stats,
    input  poker_pkg::run_t        sf_run,
    input  poker_pkg::run_t        straight_run,
    input  poker_pkg::suit_masks_t suit_masks,
    output poker_pkg::score_t      score,
    output logic                   out_valid
);
    import poker_pkg::*;

    // ====================
    // Helpers
    // ====================
    // One-hot of the highest set rank
    function automatic rank_mask_t top_onehot(input rank_mask_t m);
        rank_mask_t top;
        top = '0;
        for (int r = 0; r < NUM_RANKS; r++) begin
            if (m[r]) top = rank_mask_t'(1) << r;
        end
        return top;
    endfunction

    // Decimal rank r+1, zero when empty
    function automatic logic [3:0] onehot_dec(input rank_mask_t m);
        logic [3:0] dec;
        dec = '0;
        for (int r = 0; r < NUM_RANKS; r++) begin
            if (m[r]) dec = 4'(r + 1);
        end
        return dec;
    endfunction

    function automatic rank_mask_t clr_lowest(input rank_mask_t m);
        return m & (m - rank_mask_t'(1));
    endfunction

    rank_mask_t top_trip, second_trip;
    rank_mask_t top_pair, second_pair;
    rank_mask_t no_trip, no_pair;        // Ranks left after the top set
    rank_mask_t kick1, kick2, kick3;
    rank_mask_t flush_mask;
    score_t     score_d;

    assign top_trip    = top_onehot(stats.trips);
    assign second_trip = top_onehot(stats.trips & ~top_trip);
    assign top_pair    = top_onehot(stats.pairs);
    assign second_pair = top_onehot(stats.pairs & ~top_pair);
    assign no_trip     = stats.present & ~top_trip;
    assign no_pair     = stats.present & ~top_pair;
    assign flush_mask  = suit_masks[stats.flush_suit];

    // Pair kickers
    assign kick1 = top_onehot(no_pair);
    assign kick2 = top_onehot(no_pair & ~kick1);
    assign kick3 = top_onehot(no_pair & ~kick1 & ~kick2);

    always_comb begin
        score_d = '0;
        case (hand_class)
            ROYAL: begin
                score_d.category = CAT_ROYAL;
            end
            STRAIGHT_FLUSH: begin
                score_d.category = CAT_STRAIGHT_FLUSH;
                score_d.tiebreak = sf_run.low_onehot;
            end
            FOUR: begin
                score_d.category       = CAT_FOUR;
                score_d.tiebreak[12:9] = onehot_dec(top_onehot(stats.quads));
                score_d.tiebreak[8:5]  = onehot_dec(top_onehot(stats.present & ~stats.quads));
            end
            FULL_HOUSE: begin
                score_d.category       = CAT_FULL_HOUSE;
                score_d.tiebreak[12:9] = onehot_dec(top_trip);
                score_d.tiebreak[8:5]  = (stats.trip_cnt == 2'd2) ? onehot_dec(second_trip)
                                                                  : onehot_dec(top_pair);
            end
            FLUSH: begin
                score_d.category = CAT_FLUSH;
                case (stats.flush_cnt)      // Keep the five highest
                    3'd7:    score_d.tiebreak = clr_lowest(clr_lowest(flush_mask));
                    3'd6:    score_d.tiebreak = clr_lowest(flush_mask);
                    default: score_d.tiebreak = flush_mask;
                endcase
            end
            STRAIGHT: begin
                score_d.category = CAT_STRAIGHT;
                score_d.tiebreak = straight_run.low_onehot;
            end
            THREE: begin
                score_d.category       = CAT_THREE;
                score_d.tiebreak[12:9] = onehot_dec(top_trip);
                score_d.tiebreak[8:5]  = onehot_dec(top_onehot(no_trip));
                score_d.tiebreak[4:1]  = onehot_dec(top_onehot(no_trip & ~top_onehot(no_trip)));
            end
            TWO_PAIR: begin
                score_d.category       = CAT_TWO_PAIR;
                score_d.tiebreak[12:9] = onehot_dec(top_pair);
                score_d.tiebreak[8:5]  = onehot_dec(second_pair);
                score_d.tiebreak[4:1]  = onehot_dec(top_onehot(no_pair & ~second_pair));
            end
            PAIR: begin
                score_d.category       = PAIR_BASE + {1'b0, onehot_dec(top_pair)};
                score_d.tiebreak[12:9] = onehot_dec(kick1);
                score_d.tiebreak[8:5]  = onehot_dec(kick2);
                score_d.tiebreak[4:1]  = onehot_dec(kick3);
            end
            default: begin
                score_d.category = CAT_HIGH;
                score_d.tiebreak = clr_lowest(clr_lowest(stats.present));
            end
        endcase
    end

    // ====================
    // Stage 2 registers
    // ====================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            score     <= '0;
            out_valid <= 1'b0;
        end else begin
            out_valid <= s1_valid;
            if (s1_valid) begin
                score <= score_d;      // Held between hands
            end
        end
    end

endmodule

/* rtl/poker_eval_top.sv */
`timescale 1ns/1ns

module poker_eval_top (
    input  logic                                       clk,
    input  logic                                       rst_n,
    input  logic                                       in_valid,
    input  poker_pkg::card_t [poker_pkg::HOLE_CARDS-1:0]  hole_cards,
    input  poker_pkg::card_t [poker_pkg::BOARD_CARDS-1:0] board_cards,
    output logic                                       out_valid,
    output poker_pkg::score_t                          score
);
    import poker_pkg::*;

    suit_masks_t             suit_masks;
    logic                    s1_valid;
    rank_stats_t             stats;
    run_t                    straight_run;
    run_t [NUM_SUITS-1:0]    suit_runs;
    run_t                    sf_run;
    hand_class_e             hand_class;

    card_decoder u_card_decoder (
        .clk         (clk),
        .rst_n       (rst_n),
        .in_valid    (in_valid),
        .hole_cards  (hole_cards),
        .board_cards (board_cards),
        .suit_masks  (suit_masks),
        .s1_valid    (s1_valid)
    );

    rank_counter u_rank_counter (.suit_masks(suit_masks), .stats(stats));

    // Straight over the union of all suits
    run_finder u_run_straight (.mask(stats.present), .run(straight_run));

    for (genvar s = 0; s < NUM_SUITS; s++) begin : g_suit_run
        run_finder u_run_suit (.mask(suit_masks[s]), .run(suit_runs[s]));
    end

    hand_classifier u_hand_classifier (
        .stats        (stats),
        .straight_run (straight_run),
        .suit_runs    (suit_runs),
        .hand_class   (hand_class),
        .sf_run       (sf_run)
    );

    score_encoder u_score_encoder (
        .clk          (clk),
        .rst_n        (rst_n),
        .s1_valid     (s1_valid),
        .hand_class   (hand_class),
        .stats        (stats),
        .sf_run       (sf_run),
        .straight_run (straight_run),
        .suit_masks   (suit_masks),
        .score        (score),
        .out_valid    (out_valid)
    );

endmodule

/* dv/clk_gen.sv */
`timescale 1ns/1ns

module clk_gen (
    output logic clk,
    output logic rst_n
);

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;     // 100 ns period
    end

    initial begin
        rst_n = 1'b0;
        repeat (10) @(posedge clk);
        rst_n <= 1'b1;
    end

endmodule

/* dv/poker_eval_sva.sv */
`timescale 1ns/1ns

module poker_eval_sva (
    input logic clk,
    input logic rst_n,
    input logic in_valid,
    input logic out_valid
);

    // Two register stages between strobes
    property p_latency;
        @(posedge clk) disable iff (!rst_n)
        out_valid == $past(in_valid, 2);
    endproperty

    a_latency: assert property (p_latency)
        else $error("out_valid does not follow in_valid by two cycles");

    // Both valid stages stay empty through reset and the two edges after it
    property p_reset_idle;
        @(posedge clk)
        (!rst_n || !$past(rst_n) || !$past(rst_n, 2)) |-> !out_valid;
    endproperty

    a_reset_idle: assert property (p_reset_idle)
        else $error("out_valid high during reset or in the two cycles after it");

endmodule

bind poker_eval_top poker_eval_sva sva_i (
    .clk       (clk),
    .rst_n     (rst_n),
    .in_valid  (in_valid),
    .out_valid (out_valid)
);

/* dv/tb_top.sv */
`timescale 1ns/1ns

module tb_top;
    import poker_pkg::*;

    localparam int NUM_RANDOM   = 400;
    localparam int NUM_RARE     = 40;
    localparam int RESET_CYCLES = 10;
    localparam int MAX_CYCLES   = NUM_RANDOM + NUM_RARE + RESET_CYCLES + 50;
    localparam int MAX_GAPS     = 24;               // Keeps the run inside the cycle limit
    localparam logic [31:0] LFSR_POLY = 32'h8020_0003;

    logic                    clk;
    logic                    rst_n;
    logic                    in_valid;
    logic                    out_valid;
    card_t [HOLE_CARDS-1:0]  hole_cards;
    card_t [BOARD_CARDS-1:0] board_cards;
    score_t                  score;

    logic [31:0] lfsr = 32'd81959;
    card_t       hand [7];
    int          n_cards;
    score_t      exp_q [$];
    int          due_q [$];                         // Negedge count when each result is due
    score_t      last_score = '0;
    int          neg_cycles = 0;
    int          cycles = 0;

    clk_gen clk_gen_i (.clk(clk), .rst_n(rst_n));

    poker_eval_top dut_i (
        .clk         (clk),
        .rst_n       (rst_n),
        .in_valid    (in_valid),
        .hole_cards  (hole_cards),
        .board_cards (board_cards),
        .out_valid   (out_valid),
        .score       (score)
    );

    // ====================
    // Random source
    // ====================
    function automatic int take_bits(input int n);
        int v;
        v = 0;
        for (int i = 0; i < n; i++) begin
            v = v | (int'(lfsr[0]) << i);
            lfsr = lfsr[0] ? ((lfsr >> 1) ^ LFSR_POLY) : (lfsr >> 1);
        end
        return v;
    endfunction

    task automatic place(input int r, input int s);
        hand[n_cards] = '{num: 4'(r + 2), suit: 2'(s)};
        n_cards++;
    endtask

    // Top up the hand with distinct random cards
    task automatic fill_random();
        card_t c;
        int    v;
        logic  dup;
        while (n_cards < 7) begin
            v = take_bits(6);
            c = '{num: 4'(v % 13 + 2), suit: 2'(v / 13)};
            dup = 1'b0;
            for (int i = 0; i < n_cards; i++) begin
                if (hand[i] == c) dup = 1'b1;
            end
            if (v < 52 && !dup) begin
                hand[n_cards] = c;
                n_cards++;
            end
        end
    endtask

    task automatic build_rare(input int kind);
        int s;
        int r;
        s = take_bits(2);
        r = take_bits(4) % 13;
        n_cards = 0;
        case (kind)
            0: for (int i = 0; i < 5; i++) place(8 + i, s);          // Royal
            1: for (int i = 0; i < 5; i++) place(r % 8 + i, s);
            2: begin                                                 // Suited wheel
                place(12, s);
                for (int i = 0; i < 4; i++) place(i, s);
            end
            3: for (int i = 0; i < 4; i++) place(r, i);
            4: for (int i = 0; i < 3; i++) begin                     // Two trips
                place(r, i);
                place((r + 5) % 13, i + 1);
            end
            5: for (int i = 0; i < 7; i++) place((r + 2 * i) % 13, s);
            6: begin                                                 // Wheel, mixed suits
                place(12, s);
                for (int i = 0; i < 4; i++) place(i, take_bits(2));
            end
            default: for (int i = 0; i < 3; i++) begin              // Three pairs
                place((r + 4 * i) % 13, 0);
                place((r + 4 * i) % 13, i + 1);
            end
        endcase
        fill_random();
    endtask

    // ====================
    // Reference model
    // ====================
    function automatic int top_rank(input logic [12:0] m);
        int top;
        top = -1;
        for (int r = 0; r < 13; r++) begin
            if (m[r]) top = r;
        end
        return top;
    endfunction

    function automatic logic [12:0] drop(input logic [12:0] m, input int r);
        logic [12:0] res;
        res = m;
        if (r >= 0) res[r] = 1'b0;
        return res;
    endfunction

    function automatic logic [12:0] keep_top(input logic [12:0] m, input int n);
        logic [12:0] res;
        int          kept;
        res = '0;
        kept = 0;
        for (int r = 12; r >= 0; r--) begin
            if (m[r] && kept < n) begin
                res[r] = 1'b1;
                kept++;
            end
        end
        return res;
    endfunction

    // Low rank of the best run, -1 for the wheel, -2 for none
    function automatic int run_low(input logic [12:0] m);
        for (int lo = 8; lo >= 0; lo--) begin
            if (&m[lo +: 5]) return lo;
        end
        if (m[12] && (&m[3:0])) return -1;
        return -2;
    endfunction

    function automatic logic [12:0] low_bit(input int lo);
        return (lo >= 0) ? (13'(1) << lo) : 13'(0);
    endfunction

    function automatic score_t expected_score(input card_t [HOLE_CARDS-1:0] hole,
                                              input card_t [BOARD_CARDS-1:0] board);
        logic [12:0] m [4];
        logic [12:0] all, quads, trips, pairs, rest;
        card_t       c;
        score_t      s;
        int          cnt, fs, sflo, lo, t1, t2, p1, p2, k, n_kick;
        for (int i = 0; i < 4; i++) m[i] = '0;
        for (int i = 0; i < 7; i++) begin
            c = (i < 2) ? hole[i] : board[i - 2];
            m[c.suit][c.num - 2] = 1'b1;
        end
        for (int r = 0; r < 13; r++) begin
            cnt = 0;
            for (int su = 0; su < 4; su++) cnt += int'(m[su][r]);
            all[r]   = (cnt > 0);
            quads[r] = (cnt == 4);
            trips[r] = (cnt == 3);
            pairs[r] = (cnt == 2);
        end
        fs = -1;
        for (int su = 3; su >= 0; su--) begin
            if ($countones(m[su]) >= 5) fs = su;
        end
        sflo = (fs >= 0) ? run_low(m[fs]) : -2;    // Only a five-card suit can hold a run
        lo = run_low(all);
        t1 = top_rank(trips);
        t2 = top_rank(drop(trips, t1));
        p1 = top_rank(pairs);
        p2 = top_rank(drop(pairs, p1));
        s = '0;
        n_kick = 0;
        if (sflo == 8) begin
            s.category = CAT_ROYAL;
        end else if (sflo >= -1) begin
            s.category = CAT_STRAIGHT_FLUSH;
            s.tiebreak = low_bit(sflo);
        end else if (quads != '0) begin
            s.category = CAT_FOUR;
            s.tiebreak[12:9] = 4'(top_rank(quads) + 1);
            s.tiebreak[8:5]  = 4'(top_rank(drop(all, top_rank(quads))) + 1);
        end else if (t1 >= 0 && (t2 >= 0 || p1 >= 0)) begin
            s.category = CAT_FULL_HOUSE;
            s.tiebreak[12:9] = 4'(t1 + 1);
            s.tiebreak[8:5]  = (t2 >= 0) ? 4'(t2 + 1) : 4'(p1 + 1);
        end else if (fs >= 0) begin
            s.category = CAT_FLUSH;
            s.tiebreak = keep_top(m[fs], 5);
        end else if (lo >= -1) begin
            s.category = CAT_STRAIGHT;
            s.tiebreak = low_bit(lo);
        end else if (t1 >= 0) begin
            s.category = CAT_THREE;
            s.tiebreak[12:9] = 4'(t1 + 1);
            rest = drop(all, t1);
            n_kick = 2;
        end else if (p2 >= 0) begin
            s.category = CAT_TWO_PAIR;
            s.tiebreak[12:9] = 4'(p1 + 1);
            s.tiebreak[8:5]  = 4'(p2 + 1);
            s.tiebreak[4:1]  = 4'(top_rank(drop(drop(all, p1), p2)) + 1);
        end else if (p1 >= 0) begin
            s.category = PAIR_BASE + 5'(p1 + 1);
            rest = drop(all, p1);
            n_kick = 3;
        end else begin
            s.category = CAT_HIGH;
            s.tiebreak = keep_top(all, 5);
        end
        // Kickers fill the fields after the made ranks
        for (int j = 0; j < n_kick; j++) begin
            k = top_rank(rest);
            s.tiebreak[12 - 4 * (j + 3 - n_kick) -: 4] = 4'(k + 1);
            rest = drop(rest, k);
        end
        return s;
    endfunction

    // ====================
    // Checks
    // ====================
    task automatic check_score(input score_t act, input score_t exp, input string name);
        if (act !== exp) begin
            $display("mismatch at %0t: %s actual %h expected %h", $time, name, act, exp);
            $display("Simulation failed");
            $fatal(1, "stopping at first error");
        end
    endtask

    task automatic check_valid(input logic act, input logic exp, input string name);
        if (act !== exp) begin
            $display("mismatch at %0t: %s actual %b expected %b", $time, name, act, exp);
            $display("Simulation failed");
            $fatal(1, "stopping at first error");
        end
    endtask

    // Sample on the falling edge, away from the driving edge
    always @(negedge clk) begin
        logic exp_valid;
        neg_cycles++;
        exp_valid = (due_q.size() != 0) && (due_q[0] == neg_cycles);
        check_valid(out_valid, exp_valid, "out_valid");
        if (exp_valid) begin
            check_score(score, exp_q[0], "score");
            last_score = exp_q.pop_front();
            void'(due_q.pop_front());
        end else begin
            check_score(score, last_score, "score");   // Held between results
        end
        if (in_valid === 1'b1) begin
            exp_q.push_back(expected_score(hole_cards, board_cards));
            due_q.push_back(neg_cycles + 2);
        end
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles > MAX_CYCLES) begin
            $display("run did not finish within %0d cycles", MAX_CYCLES);
            $display("Simulation failed");
            $fatal(1, "timeout");
        end
    end

    // ====================
    // Stimulus
    // ====================
    task automatic send_hand();
        @(posedge clk);
        in_valid <= 1'b1;
        for (int i = 0; i < HOLE_CARDS; i++) hole_cards[i] <= hand[i];
        for (int i = 0; i < BOARD_CARDS; i++) board_cards[i] <= hand[i + HOLE_CARDS];
    endtask

    task automatic idle();
        @(posedge clk);
        in_valid <= 1'b0;
    endtask

    initial begin
        int gaps;
        gaps = 0;
        in_valid    = 1'b0;
        hole_cards  = '0;
        board_cards = '0;
        wait (rst_n === 1'b1);
        @(posedge clk);
        for (int i = 0; i < NUM_RANDOM; i++) begin
            n_cards = 0;
            fill_random();
            send_hand();
            // First half back to back, then the odd idle cycle
            if (i >= NUM_RANDOM / 2 && gaps < MAX_GAPS && take_bits(2) == 0) begin
                idle();
                gaps++;
            end
        end
        for (int i = 0; i < NUM_RARE; i++) begin
            build_rare(i % 8);
            send_hand();
        end
        idle();
        while (exp_q.size() != 0) @(posedge clk);
        repeat (3) @(posedge clk);
        $display("Simulation passed");
        $finish;
    end

endmodule

/* project.f */
rtl/poker_pkg.sv
rtl/card_decoder.sv
rtl/rank_counter.sv
rtl/run_finder.sv
rtl/hand_classifier.sv
rtl/score_encoder.sv
rtl/poker_eval_top.sv
dv/clk_gen.sv
dv/poker_eval_sva.sv
dv/tb_top.sv

/* run.sh */
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module tb_top -f project.f -o tb_sim

# The simulator's own exit status is not trusted, the log decides
./obj_dir/tb_sim > sim.log 2>&1 || true
cat sim.log

if grep -qx "Simulation passed" sim.log; then
    exit 0
else
    exit 1
fi
